// ==== design/mem_types_pkg.sv ====
`default_nettype none

package mem_types_pkg;

    // cpu side
    typedef logic [31:0] addr_t;            // byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;           // one bit per byte

    // line and burst side
    typedef logic [255:0] line_t;           // 32 bytes
    typedef logic [63:0]  beat_t;

    localparam int BEATS_PER_LINE = 4;      // 256 / 64

    typedef logic [1:0] beat_idx_t;         // indexes the beats of one line

endpackage : mem_types_pkg

`default_nettype wire

// ==== design/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    typedef struct packed {
        logic                  read;
        logic                  write;
        mem_types_pkg::addr_t  addr;
        mem_types_pkg::wmask_t wmask;
        mem_types_pkg::word_t  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                 resp;        // one-cycle pulse
        mem_types_pkg::word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic                 read;
        logic                 write;
        mem_types_pkg::addr_t addr;        // line aligned
        mem_types_pkg::line_t wdata;
    } line_req_t;

    typedef struct packed {
        logic                 resp;
        mem_types_pkg::line_t rdata;
    } line_rsp_t;

endpackage : mem_bus_pkg

`default_nettype wire

// ==== design/burst_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module burst_counter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear_i,
    input  logic                     step_i,
    output mem_types_pkg::beat_idx_t idx_o,
    output logic                     last_o
);

    mem_types_pkg::beat_idx_t idx_q;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            idx_q <= '0;
        end else if (step_i) begin
            idx_q <= idx_q + 1'b1;              // wraps after the last beat
        end
    end

    assign idx_o  = idx_q;
    assign last_o = step_i && (int'(idx_q) == mem_types_pkg::BEATS_PER_LINE - 1);

endmodule : burst_counter

`default_nettype wire

// ==== design/line_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_cache #(
    parameter int LOG2_SETS = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_bus_pkg::cpu_req_t  cpu_req_i,
    output mem_bus_pkg::cpu_rsp_t  cpu_rsp_o,
    output mem_bus_pkg::line_req_t line_req_o,
    input  mem_bus_pkg::line_rsp_t line_rsp_i
);

    localparam int SETS  = 2 ** LOG2_SETS;
    localparam int OFF_W = 5;                       // byte offset within a line
    localparam int TAG_W = 32 - LOG2_SETS - OFF_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITEBACK,
        S_FILL,
        S_SERVE
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [TAG_W-1:0]     tag_q [SETS];
    mem_types_pkg::line_t line_q [SETS];
    logic [SETS-1:0]      valid_q;
    logic [SETS-1:0]      dirty_q;

    logic [LOG2_SETS-1:0] idx;
    logic [TAG_W-1:0]     tag;
    logic [2:0]           word_sel;
    logic                 req_active;
    logic                 hit;
    logic                 do_access;
    logic                 fill_done;

    mem_types_pkg::line_t cur_line;
    mem_types_pkg::line_t merged_line;
    mem_types_pkg::word_t cur_word;

    logic                 resp_q;
    mem_types_pkg::word_t rdata_q;

    assign idx      = cpu_req_i.addr[OFF_W +: LOG2_SETS];
    assign tag      = cpu_req_i.addr[31 -: TAG_W];
    assign word_sel = cpu_req_i.addr[4:2];

    // a held request is ignored in the cycle its resp is out
    assign req_active = (cpu_req_i.read || cpu_req_i.write) && !resp_q;

    assign cur_line  = line_q[idx];
    assign cur_word  = cur_line[{word_sel, 5'b0} +: 32];
    assign hit       = valid_q[idx] && (tag_q[idx] == tag);
    assign do_access = req_active && hit && (state_q == S_IDLE || state_q == S_SERVE);
    assign fill_done = (state_q == S_FILL) && line_rsp_i.resp;

    // byte merge of the store into the current line
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < 4; b++) begin
            if (cpu_req_i.wmask[b]) begin
                merged_line[{word_sel, 5'b0} + b * 8 +: 8] = cpu_req_i.wdata[b * 8 +: 8];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_active && !hit) begin
                    // victim goes out first if modified
                    state_d = (valid_q[idx] && dirty_q[idx]) ? S_WRITEBACK : S_FILL;
                end
            end
            S_WRITEBACK: begin
                if (line_rsp_i.resp) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (line_rsp_i.resp) begin
                    state_d = S_SERVE;
                end
            end
            S_SERVE: state_d = S_IDLE;             // access done via do_access
            default: state_d = S_IDLE;
        endcase
    end

    always_comb begin
        line_req_o.read  = (state_q == S_FILL);
        line_req_o.write = (state_q == S_WRITEBACK);
        if (state_q == S_WRITEBACK) begin
            line_req_o.addr = {tag_q[idx], idx, 5'b0};  // victim address
        end else begin
            line_req_o.addr = {tag, idx, 5'b0};
        end
        line_req_o.wdata = cur_line;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            resp_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            resp_q  <= do_access;
            if (state_q == S_WRITEBACK && line_rsp_i.resp) begin
                dirty_q[idx] <= 1'b0;
            end
            if (fill_done) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end
            if (do_access && cpu_req_i.write) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    // line, tag and read data storage
    always_ff @(posedge clk) begin
        if (fill_done) begin
            line_q[idx] <= line_rsp_i.rdata;
            tag_q[idx]  <= tag;
        end else if (do_access && cpu_req_i.write) begin
            line_q[idx] <= merged_line;
        end
        if (do_access) begin
            rdata_q <= cur_word;
        end
    end

    assign cpu_rsp_o.resp  = resp_q;
    assign cpu_rsp_o.rdata = rdata_q;

endmodule : line_cache

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_bus_pkg::line_req_t i_req_i,
    input  mem_bus_pkg::line_req_t d_req_i,
    output mem_bus_pkg::line_rsp_t i_rsp_o,
    output mem_bus_pkg::line_rsp_t d_rsp_o,
    output mem_bus_pkg::line_req_t mem_req_o,
    input  mem_bus_pkg::line_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_GRANT_I,
        S_GRANT_D
    } state_t;

    state_t state_q;
    state_t state_d;

    logic i_pending;
    logic d_pending;

    assign i_pending = i_req_i.read || i_req_i.write;
    assign d_pending = d_req_i.read || d_req_i.write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (d_pending) begin
                    state_d = S_GRANT_D;           // data side wins a tie
                end else if (i_pending) begin
                    state_d = S_GRANT_I;
                end
            end
            S_GRANT_I, S_GRANT_D: begin
                if (mem_rsp_i.resp) begin
                    state_d = S_IDLE;             // grant held until line resp
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // owner's request goes through, nothing while idle
    always_comb begin
        case (state_q)
            S_GRANT_I: mem_req_o = i_req_i;
            S_GRANT_D: mem_req_o = d_req_i;
            default:   mem_req_o = '0;
        endcase
    end

    assign i_rsp_o.resp  = mem_rsp_i.resp && (state_q == S_GRANT_I);
    assign i_rsp_o.rdata = mem_rsp_i.rdata;
    assign d_rsp_o.resp  = mem_rsp_i.resp && (state_q == S_GRANT_D);
    assign d_rsp_o.rdata = mem_rsp_i.rdata;

endmodule : mem_arbiter

`default_nettype wire

// ==== design/cacheline_adaptor.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheline_adaptor (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_bus_pkg::line_req_t line_req_i,
    output mem_bus_pkg::line_rsp_t line_rsp_o,
    output mem_types_pkg::addr_t   bmem_address_o,
    output logic                   bmem_read_o,
    output logic                   bmem_write_o,
    output mem_types_pkg::beat_t   bmem_wdata_o,
    input  mem_types_pkg::beat_t   bmem_rdata_i,
    input  logic                   bmem_resp_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_DONE
    } state_t;

    state_t state_q;
    logic   started_q;                          // first beat response seen
    logic   busy;
    logic   step;
    logic   last;

    mem_types_pkg::beat_idx_t idx;
    mem_types_pkg::line_t     line_q;

    assign busy = (state_q == S_READ) || (state_q == S_WRITE);
    assign step = busy && bmem_resp_i;

    burst_counter i_burst_counter (
        .clk     (clk),
        .rst     (rst),
        .clear_i (state_q == S_IDLE),           // restart at every burst
        .step_i  (step),
        .idx_o   (idx),
        .last_o  (last)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= S_IDLE;
            started_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    started_q <= 1'b0;
                    if (line_req_i.read) begin
                        state_q <= S_READ;
                    end else if (line_req_i.write) begin
                        state_q <= S_WRITE;
                    end
                end
                S_READ, S_WRITE: begin
                    if (bmem_resp_i) begin
                        started_q <= 1'b1;
                    end
                    if (last) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;   // S_DONE, one-cycle line resp
            endcase
        end
    end

    // read beats land in the assembly register
    always_ff @(posedge clk) begin
        if (step && state_q == S_READ) begin
            line_q[{idx, 6'b0} +: 64] <= bmem_rdata_i;
        end
    end

    assign bmem_address_o = {line_req_i.addr[31:5], 5'b0};
    assign bmem_read_o    = (state_q == S_READ) && !started_q;
    assign bmem_write_o   = (state_q == S_WRITE) && !started_q;
    assign bmem_wdata_o   = line_req_i.wdata[{idx, 6'b0} +: 64];

    assign line_rsp_o.resp  = (state_q == S_DONE);
    assign line_rsp_o.rdata = line_q;

endmodule : cacheline_adaptor

`default_nettype wire

// ==== design/mem_hier_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hier_top #(
    parameter int I_LOG2_SETS = 3,
    parameter int D_LOG2_SETS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::cpu_req_t imem_req_i,
    output mem_bus_pkg::cpu_rsp_t imem_rsp_o,
    input  mem_bus_pkg::cpu_req_t dmem_req_i,
    output mem_bus_pkg::cpu_rsp_t dmem_rsp_o,
    output mem_types_pkg::addr_t  bmem_address_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output mem_types_pkg::beat_t  bmem_wdata_o,
    input  mem_types_pkg::beat_t  bmem_rdata_i,
    input  logic                  bmem_resp_i
);

    mem_bus_pkg::cpu_req_t  icache_req;         // fetch port, never writes
    mem_bus_pkg::line_req_t i_line_req;
    mem_bus_pkg::line_rsp_t i_line_rsp;
    mem_bus_pkg::line_req_t d_line_req;
    mem_bus_pkg::line_rsp_t d_line_rsp;
    mem_bus_pkg::line_req_t mem_req;
    mem_bus_pkg::line_rsp_t mem_rsp;

    assign icache_req = mem_bus_pkg::cpu_req_t'{
        read:  imem_req_i.read,
        write: 1'b0,
        addr:  imem_req_i.addr,
        wmask: imem_req_i.wmask,
        wdata: imem_req_i.wdata
    };

    line_cache #(
        .LOG2_SETS (I_LOG2_SETS)
    ) i_icache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req_i  (icache_req),
        .cpu_rsp_o  (imem_rsp_o),
        .line_req_o (i_line_req),
        .line_rsp_i (i_line_rsp)
    );

    line_cache #(
        .LOG2_SETS (D_LOG2_SETS)
    ) i_dcache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req_i  (dmem_req_i),
        .cpu_rsp_o  (dmem_rsp_o),
        .line_req_o (d_line_req),
        .line_rsp_i (d_line_rsp)
    );

    mem_arbiter i_mem_arbiter (
        .clk       (clk),
        .rst       (rst),
        .i_req_i   (i_line_req),
        .d_req_i   (d_line_req),
        .i_rsp_o   (i_line_rsp),
        .d_rsp_o   (d_line_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    cacheline_adaptor i_cacheline_adaptor (
        .clk            (clk),
        .rst            (rst),
        .line_req_i     (mem_req),
        .line_rsp_o     (mem_rsp),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : mem_hier_top

`default_nettype wire

// ==== sim/mem_hier_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hier_checker (
    input logic                   clk,
    input logic                   rst,
    input mem_bus_pkg::cpu_req_t  imem_req_i,
    input mem_bus_pkg::cpu_rsp_t  imem_rsp_i,
    input mem_bus_pkg::cpu_req_t  dmem_req_i,
    input mem_bus_pkg::cpu_rsp_t  dmem_rsp_i,
    input mem_bus_pkg::line_req_t i_line_req_i,
    input mem_bus_pkg::line_req_t d_line_req_i,
    input logic                   bmem_read_i,
    input logic                   bmem_write_i
);

    int unsigned fail_count = 0;

    logic i_req;
    logic d_req;
    logic i_seen;
    logic d_seen;

    logic        i_repeat;
    logic        d_repeat;
    logic        i_last_vld;
    logic        d_last_vld;
    logic [26:0] i_last_line;                   // line of the last answered request
    logic [26:0] d_last_line;

    assign i_req  = imem_req_i.read || imem_req_i.write;
    assign d_req  = dmem_req_i.read || dmem_req_i.write;
    assign i_seen = i_req && !imem_rsp_i.resp;  // request not yet answered
    assign d_seen = d_req && !dmem_rsp_i.resp;

    // same line as the last answered request is still resident
    assign i_repeat = i_last_vld && (imem_req_i.addr[31:5] == i_last_line);
    assign d_repeat = d_last_vld && (dmem_req_i.addr[31:5] == d_last_line);

    always_ff @(posedge clk) begin
        if (rst) begin
            i_last_vld <= 1'b0;
            d_last_vld <= 1'b0;
        end else begin
            if (imem_rsp_i.resp) begin
                i_last_vld  <= 1'b1;
                i_last_line <= imem_req_i.addr[31:5];
            end
            if (dmem_rsp_i.resp) begin
                d_last_vld  <= 1'b1;
                d_last_line <= dmem_req_i.addr[31:5];
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        rst |=> !imem_rsp_i.resp && !dmem_rsp_i.resp && !bmem_read_i && !bmem_write_i)
        else begin
            $error("resp or burst strobe active right after reset");
            fail_count++;
        end

    a_no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_i && bmem_write_i))
        else begin
            $error("bmem_read and bmem_write high in the same cycle");
            fail_count++;
        end

    a_imem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        imem_rsp_i.resp |-> i_req ##1 !imem_rsp_i.resp)
        else begin
            $error("instruction resp without request or longer than one cycle");
            fail_count++;
        end

    a_dmem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        dmem_rsp_i.resp |-> d_req ##1 !dmem_rsp_i.resp)
        else begin
            $error("data resp without request or longer than one cycle");
            fail_count++;
        end

    // a fresh request either hits next cycle or starts a line request
    a_imem_hit_latency: assert property (@(posedge clk) disable iff (rst)
        (i_seen && !$past(i_seen)) |=>
            (imem_rsp_i.resp ||
             (!$past(i_repeat) && (i_line_req_i.read || i_line_req_i.write))))
        else begin
            $error("instruction cache neither hit in one cycle nor started a miss");
            fail_count++;
        end

    a_dmem_hit_latency: assert property (@(posedge clk) disable iff (rst)
        (d_seen && !$past(d_seen)) |=>
            (dmem_rsp_i.resp ||
             (!$past(d_repeat) && (d_line_req_i.read || d_line_req_i.write))))
        else begin
            $error("data cache neither hit in one cycle nor started a miss");
            fail_count++;
        end

endmodule : mem_hier_checker

`default_nettype wire

// ==== sim/mem_hier_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hier_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 4;
    localparam int MEM_WORDS      = 2048;       // 8 KiB behind the burst bus
    localparam int CYCLES_PER_REQ = 400;

    logic clk;
    logic rst;

    mem_bus_pkg::cpu_req_t imem_req;
    mem_bus_pkg::cpu_rsp_t imem_rsp;
    mem_bus_pkg::cpu_req_t dmem_req;
    mem_bus_pkg::cpu_rsp_t dmem_rsp;

    mem_types_pkg::addr_t bmem_address;
    logic                 bmem_read;
    logic                 bmem_write;
    logic                 bmem_resp;
    mem_types_pkg::beat_t bmem_wdata;
    mem_types_pkg::beat_t bmem_rdata;

    mem_types_pkg::word_t mem_q [MEM_WORDS];
    mem_types_pkg::word_t shadow_q [MEM_WORDS];  // cpu view after every write

    mem_types_pkg::word_t i_expect;
    mem_types_pkg::word_t d_expect;
    logic                 i_check;
    logic                 d_check;
    string                i_test;
    string                d_test;

    logic [31:0] rng_state = 32'h84d385f4;
    int unsigned errors    = 0;
    int unsigned req_count = 0;

    mem_hier_top i_mem_hier_top (
        .clk            (clk),
        .rst            (rst),
        .imem_req_i     (imem_req),
        .imem_rsp_o     (imem_rsp),
        .dmem_req_i     (dmem_req),
        .dmem_rsp_o     (dmem_rsp),
        .bmem_address_o (bmem_address),
        .bmem_read_o    (bmem_read),
        .bmem_write_o   (bmem_write),
        .bmem_wdata_o   (bmem_wdata),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_resp_i    (bmem_resp)
    );

    bind mem_hier_top mem_hier_checker i_mem_hier_checker (
        .clk          (clk),
        .rst          (rst),
        .imem_req_i   (icache_req),
        .imem_rsp_i   (imem_rsp_o),
        .dmem_req_i   (dmem_req_i),
        .dmem_rsp_i   (dmem_rsp_o),
        .i_line_req_i (i_line_req),
        .d_line_req_i (d_line_req),
        .bmem_read_i  (bmem_read_o),
        .bmem_write_i (bmem_write_o)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic mem_types_pkg::word_t pattern_word(input mem_types_pkg::addr_t addr);
        return addr ^ 32'h5a5a5a5a;
    endfunction

    function automatic mem_types_pkg::word_t merge_bytes(input mem_types_pkg::word_t old,
                                                         input mem_types_pkg::word_t wdata,
                                                         input mem_types_pkg::wmask_t mask);
        mem_types_pkg::word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return res;
    endfunction

    a_imem_rdata: assert property (@(posedge clk) disable iff (rst)
        (imem_rsp.resp && i_check) |-> (imem_rsp.rdata == i_expect))
        else begin
            $display("Mismatch %s: expected %08h, actual %08h", i_test,
                     $sampled(i_expect), $sampled(imem_rsp.rdata));
            errors++;
        end

    a_dmem_rdata: assert property (@(posedge clk) disable iff (rst)
        (dmem_rsp.resp && d_check) |-> (dmem_rsp.rdata == d_expect))
        else begin
            $display("Mismatch %s: expected %08h, actual %08h", d_test,
                     $sampled(d_expect), $sampled(dmem_rsp.rdata));
            errors++;
        end

    task automatic fetch(input mem_types_pkg::addr_t addr, input string name);
        imem_req.read = 1'b1;
        imem_req.addr = addr;
        i_expect      = shadow_q[addr[12:2]];
        i_test        = name;
        i_check       = 1'b1;
        req_count++;
        @(posedge clk);
        #DRIVE_DELAY;
        while (!imem_rsp.resp) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);                         // hold through the resp cycle
        #DRIVE_DELAY;
        imem_req = '0;
        i_check  = 1'b0;
    endtask

    task automatic data_access(input logic write, input mem_types_pkg::addr_t addr,
                               input mem_types_pkg::wmask_t mask,
                               input mem_types_pkg::word_t wdata, input string name);
        dmem_req.read  = !write;
        dmem_req.write = write;
        dmem_req.addr  = addr;
        dmem_req.wmask = mask;
        dmem_req.wdata = wdata;
        d_expect       = shadow_q[addr[12:2]];
        d_test         = name;
        d_check        = !write;
        req_count++;
        @(posedge clk);
        #DRIVE_DELAY;
        while (!dmem_rsp.resp) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        dmem_req = '0;
        d_check  = 1'b0;
        if (write) begin
            shadow_q[addr[12:2]] = merge_bytes(shadow_q[addr[12:2]], wdata, mask);
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // four beats per burst after a random wait
    initial begin : burst_memory
        logic        is_write;
        int unsigned base;
        int unsigned delay;
        bmem_resp  = 1'b0;
        bmem_rdata = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (bmem_read || bmem_write) begin
                is_write = bmem_write;
                base     = bmem_address[12:2];
                delay    = (lcg_next() >> 16) % 5;
                repeat (delay) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                for (int b = 0; b < mem_types_pkg::BEATS_PER_LINE; b++) begin
                    bmem_resp = 1'b1;
                    if (is_write) begin
                        mem_q[base + 2 * b]     = bmem_wdata[31:0];
                        mem_q[base + 2 * b + 1] = bmem_wdata[63:32];
                    end else begin
                        bmem_rdata = {mem_q[base + 2 * b + 1], mem_q[base + 2 * b]};
                    end
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                bmem_resp = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLES_PER_REQ * (req_count + 1)) begin
                $display("Timeout: no response after %0d cycles with %0d requests issued",
                         cycles, req_count);
                $display("Errors: %0d read data, %0d protocol", errors,
                         i_mem_hier_top.i_mem_hier_checker.fail_count);
                $display("Test failed");
                $finish;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int unsigned total;
        rst      = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        i_check  = 1'b0;
        d_check  = 1'b0;
        i_expect = '0;
        d_expect = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_q[w]    = pattern_word(w * 4);
            shadow_q[w] = pattern_word(w * 4);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        fetch(32'h0000_0000, "fetch_miss");
        fetch(32'h0000_0004, "fetch_hit");
        fetch(32'h0000_001c, "fetch_hit_last_word");
        fetch(32'h0000_0020, "fetch_next_line");
        fetch(32'h0000_0000, "fetch_rehit");

        data_access(1'b1, 32'h0000_0904, 4'b0101, 32'h1122_3344, "partial_write");
        data_access(1'b0, 32'h0000_0904, 4'b0000, '0, "partial_read");

        // 0x840 and 0xa40 share a data cache set
        data_access(1'b1, 32'h0000_0840, 4'b1111, 32'hdead_beef, "dirty_write");
        data_access(1'b0, 32'h0000_0a40, 4'b0000, '0, "conflict_read");
        data_access(1'b0, 32'h0000_0840, 4'b0000, '0, "refill_read");

        fork
            fetch(32'h0000_0100, "joint_fetch");
            data_access(1'b0, 32'h0000_0c08, 4'b0000, '0, "joint_load");
        join
        data_access(1'b1, 32'h0000_0e08, 4'b1100, 32'h7788_99aa, "joint_dirty_write");
        fork
            fetch(32'h0000_0140, "joint_fetch_wb");
            data_access(1'b0, 32'h0000_0c08, 4'b0000, '0, "joint_load_wb");
        join

        for (int n = 0; n < 16; n++) begin
            rnd = lcg_next();
            data_access(rnd[31], 32'h0000_0800 + (rnd & 32'h0000_0ffc), rnd[7:4],
                        lcg_next(), "random_access");
        end

        repeat (4) @(posedge clk);
        total = errors + i_mem_hier_top.i_mem_hier_checker.fail_count;
        $display("Errors: %0d read data, %0d protocol", errors,
                 i_mem_hier_top.i_mem_hier_checker.fail_count);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : mem_hier_tb

`default_nettype wire

// ==== filelist.f ====
design/mem_types_pkg.sv
design/mem_bus_pkg.sv
design/burst_counter.sv
design/line_cache.sv
design/mem_arbiter.sv
design/cacheline_adaptor.sv
design/mem_hier_top.sv
sim/mem_hier_checker.sv
sim/mem_hier_tb.sv

// ==== Bender.yml ====
package:
  name: mem_hier

sources:
  - design/mem_types_pkg.sv
  - design/mem_bus_pkg.sv
  - design/burst_counter.sv
  - design/line_cache.sv
  - design/mem_arbiter.sv
  - design/cacheline_adaptor.sv
  - design/mem_hier_top.sv
  - target: test
    files:
      - sim/mem_hier_checker.sv
      - sim/mem_hier_tb.sv
